/* source/bp_arch_pkg.sv */
/*
  Address types and constants shared by the fetch front end.
  Instructions are fixed 4-byte words, so no compressed encoding is supported.
  EMPTY_TAG is unaligned and can never equal a real fetch address.
*/

package bp_arch_pkg;

    localparam int ADDR_W = 64;                 // RV64 instruction address width

    typedef logic [ADDR_W-1:0] addr_t;

    // Sequential path increment
    localparam addr_t INSTR_STEP = 64'd4;

    // First fetch address after reset
    localparam addr_t RESET_PC = 64'h0000_0000_0000_1000;

    // Tag of an unused table slot
    localparam addr_t EMPTY_TAG = '1;

endpackage

/* source/bp_btb_pkg.sv */
/*
  Branch target buffer record layouts.
  An entry is 129 bits: jump pc, jump target and the executed flag.
  The exec flag marks entries learned from the execute stage, which
  pre-decoded reports are not allowed to overwrite.
*/

package bp_btb_pkg;

    // One slot of the MRU-ordered table
    typedef struct packed {
        bp_arch_pkg::addr_t pc;     // Jump instruction address
        bp_arch_pkg::addr_t npc;    // Jump target
        logic               exec;   // Learned from an executed jump
    } btb_entry_t;

    // Registered write request from the update arbiter
    typedef struct packed {
        logic               we;
        bp_arch_pkg::addr_t pc;
        bp_arch_pkg::addr_t npc;
        logic               exec;
    } btb_update_t;

    // Tags and targets, compared and loaded as a whole address

endpackage

/* source/bp_update_arb.sv */
/*
  Picks one jump report per cycle and registers it as a BTB write request.
  Executed reports win; a pre-decoded report in the same cycle is lost.
  Report strobes are single cycle, there is no handshake back to the sources.
*/

module bp_update_arb (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_ex_valid,
    input  bp_arch_pkg::addr_t      i_ex_pc,
    input  bp_arch_pkg::addr_t      i_ex_npc,
    input  logic                    i_dec_valid,
    input  bp_arch_pkg::addr_t      i_dec_pc,
    input  bp_arch_pkg::addr_t      i_dec_npc,
    output bp_btb_pkg::btb_update_t o_upd
);

    bp_btb_pkg::btb_update_t upd_next;
    logic                    dec_useful;
    logic                    upd_we;
    bp_arch_pkg::addr_t      upd_pc;
    bp_arch_pkg::addr_t      upd_npc;
    logic                    upd_exec;

    // A pre-decoded jump to the fall-through address predicts nothing
    assign dec_useful = i_dec_valid && (i_dec_npc != i_dec_pc + bp_arch_pkg::INSTR_STEP);

    always_comb begin
        upd_next.we = i_ex_valid || dec_useful;
        if (i_ex_valid) begin
            upd_next.pc   = i_ex_pc;
            upd_next.npc  = i_ex_npc;
            upd_next.exec = 1'b1;
        end else begin
            upd_next.pc   = i_dec_pc;
            upd_next.npc  = i_dec_npc;
            upd_next.exec = 1'b0;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            upd_we <= 1'b0;
        end else begin
            upd_we <= upd_next.we;
        end
    end

    // Payload is only meaningful while upd_we is set
    always_ff @(posedge i_clk) begin
        upd_pc   <= upd_next.pc;
        upd_npc  <= upd_next.npc;
        upd_exec <= upd_next.exec;
    end

    assign o_upd = '{we: upd_we, pc: upd_pc, npc: upd_npc, exec: upd_exec};

    // A lone report produces exactly one write cycle
    a_single_write: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_upd.we && !i_ex_valid && !i_dec_valid) |=> !o_upd.we);

endmodule

/* source/bp_btb.sv */
/*
  Fully associative BTB kept in most-recently-used order, slot 0 newest.
  Assumes pc values in the table are unique, which the hit-aware insert keeps.
  The prediction chain is combinational from i_bp_pc; BP_DEPTH must be 2 or more.
  A flush empties the table on the next edge and overrides a pending write.
*/

module bp_btb #(
    parameter int BTB_SIZE = 8,
    parameter int BP_DEPTH = 4
) (
    input  logic                              i_clk,
    input  logic                              i_nrst,
    input  logic                              i_flush,
    input  bp_btb_pkg::btb_update_t           i_upd,
    input  bp_arch_pkg::addr_t                i_bp_pc,
    output bp_arch_pkg::addr_t [BP_DEPTH-1:0] o_pred_npc,
    output logic [BP_DEPTH-1:0]               o_pred_exec
);

    bp_btb_pkg::btb_entry_t tbl      [BTB_SIZE];
    bp_btb_pkg::btb_entry_t tbl_next [BTB_SIZE];
    logic [BTB_SIZE-1:0]    upd_hit;
    logic [BTB_SIZE-1:0]    keep_slot;          // Slot lies behind the hit, stays put
    logic [BTB_SIZE-1:0]    tbl_exec;
    logic                   upd_blocked;

    // Match the update against the table
    always_comb begin
        upd_blocked = 1'b0;
        for (int i = 0; i < BTB_SIZE; i++) begin
            upd_hit[i]  = (tbl[i].pc == i_upd.pc);
            tbl_exec[i] = tbl[i].exec;
            // Executed entry is protected from pre-decoded overwrite
            upd_blocked = upd_blocked | (upd_hit[i] & tbl[i].exec & ~i_upd.exec);
        end
        keep_slot[0] = 1'b0;
        for (int i = 1; i < BTB_SIZE; i++) begin
            keep_slot[i] = keep_slot[i-1] | upd_hit[i-1];
        end
    end

    // Next table contents
    always_comb begin
        tbl_next = tbl;
        if (i_flush) begin
            for (int i = 0; i < BTB_SIZE; i++) begin
                tbl_next[i].pc   = bp_arch_pkg::EMPTY_TAG;
                tbl_next[i].exec = 1'b0;
            end
        end else if (i_upd.we && !upd_blocked) begin
            tbl_next[0] = '{pc: i_upd.pc, npc: i_upd.npc, exec: i_upd.exec};
            for (int i = 1; i < BTB_SIZE; i++) begin
                if (!keep_slot[i]) begin
                    tbl_next[i] = tbl[i-1];     // Shift toward the tail, last one drops out
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < BTB_SIZE; i++) begin
                tbl[i] <= '{pc: bp_arch_pkg::EMPTY_TAG, npc: '0, exec: 1'b0};
            end
        end else begin
            tbl <= tbl_next;
        end
    end

    // Unroll the predicted fetch path
    always_comb begin
        bp_arch_pkg::addr_t prev_pc;
        bp_arch_pkg::addr_t next_pc;
        logic               next_exec;

        prev_pc        = i_bp_pc;
        o_pred_npc[0]  = i_bp_pc;
        o_pred_exec[0] = 1'b0;
        for (int d = 1; d < BP_DEPTH; d++) begin
            next_pc   = prev_pc + bp_arch_pkg::INSTR_STEP;  // Miss falls through
            next_exec = 1'b0;
            // Walk from the tail so the newest match is the one kept
            for (int n = BTB_SIZE - 1; n >= 0; n--) begin
                if (tbl[n].pc == prev_pc) begin
                    next_pc   = tbl[n].npc;
                    next_exec = tbl[n].exec;
                end
            end
            o_pred_npc[d]  = next_pc;
            o_pred_exec[d] = next_exec;
            prev_pc        = next_pc;
        end
    end

    // Chain head must track the fetch address from the sequencer
    a_chain_head: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_pred_npc[0] == i_bp_pc);

    // No executed entry survives a flush, even with a write pending
    a_flush_clears: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_flush |=> (tbl_exec == '0));

endmodule

/* source/bp_fetch_seq.sv */
/*
  Fetch address register, stepped along chain element 1 of the BTB.
  Redirect has priority over advance; i_fetch_en low holds the address.
  The next address is chosen in the same cycle as the chain is computed.
*/

module bp_fetch_seq #(
    parameter int BP_DEPTH = 4
) (
    input  logic                              i_clk,
    input  logic                              i_nrst,
    input  logic                              i_fetch_en,
    input  logic                              i_redirect,
    input  bp_arch_pkg::addr_t                i_redirect_pc,
    input  bp_arch_pkg::addr_t [BP_DEPTH-1:0] i_pred_npc,
    output bp_arch_pkg::addr_t                o_fetch_pc
);

    bp_arch_pkg::addr_t fetch_pc;
    bp_arch_pkg::addr_t fetch_pc_next;

    always_comb begin
        if (i_redirect) begin
            fetch_pc_next = i_redirect_pc;      // Taken from execute, overrides prediction
        end else if (i_fetch_en) begin
            fetch_pc_next = i_pred_npc[1];
        end else begin
            fetch_pc_next = fetch_pc;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            fetch_pc <= bp_arch_pkg::RESET_PC;
        end else begin
            fetch_pc <= fetch_pc_next;
        end
    end

    assign o_fetch_pc = fetch_pc;

    // Aligned redirect target gives an aligned fetch address
    a_redirect_aligned: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_redirect && (i_redirect_pc[1:0] == 2'b00)) |=> (o_fetch_pc[1:0] == 2'b00));

endmodule

/* source/bp_top.sv */
/*
  Branch prediction front end: update arbiter, BTB and fetch sequencer.
  BTB_SIZE and BP_DEPTH are set here and passed down (BP_DEPTH >= 2).
  A report reaches the prediction chain two clock edges after it is sampled.
*/

module bp_top #(
    parameter int BTB_SIZE = 8,
    parameter int BP_DEPTH = 4
) (
    input  logic                              i_clk,
    input  logic                              i_nrst,
    input  logic                              i_flush,
    input  logic                              i_ex_valid,
    input  bp_arch_pkg::addr_t                i_ex_pc,
    input  bp_arch_pkg::addr_t                i_ex_npc,
    input  logic                              i_dec_valid,
    input  bp_arch_pkg::addr_t                i_dec_pc,
    input  bp_arch_pkg::addr_t                i_dec_npc,
    input  logic                              i_fetch_en,
    input  logic                              i_redirect,
    input  bp_arch_pkg::addr_t                i_redirect_pc,
    output bp_arch_pkg::addr_t                o_fetch_pc,
    output bp_arch_pkg::addr_t [BP_DEPTH-1:0] o_pred_npc,
    output logic [BP_DEPTH-1:0]               o_pred_exec
);

    bp_btb_pkg::btb_update_t upd;       // Registered write request

    bp_update_arb u_arb (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_ex_valid  (i_ex_valid),
        .i_ex_pc     (i_ex_pc),
        .i_ex_npc    (i_ex_npc),
        .i_dec_valid (i_dec_valid),
        .i_dec_pc    (i_dec_pc),
        .i_dec_npc   (i_dec_npc),
        .o_upd       (upd)
    );

    bp_btb #(
        .BTB_SIZE (BTB_SIZE),
        .BP_DEPTH (BP_DEPTH)
    ) u_btb (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_flush     (i_flush),
        .i_upd       (upd),
        .i_bp_pc     (o_fetch_pc),      // Chain starts at the current fetch address
        .o_pred_npc  (o_pred_npc),
        .o_pred_exec (o_pred_exec)
    );

    bp_fetch_seq #(
        .BP_DEPTH (BP_DEPTH)
    ) u_seq (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_fetch_en    (i_fetch_en),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_pred_npc    (o_pred_npc),
        .o_fetch_pc    (o_fetch_pc)
    );

endmodule

/* verif/bp_tb_ref.svh */
/*
  Reference model of the fetch front end, included inside the testbench module.
  BTB_SIZE, BP_DEPTH and the DUT input signals must be declared before the include.
*/
`ifndef BP_TB_REF_SVH
`define BP_TB_REF_SVH

bp_btb_pkg::btb_entry_t  ref_tbl [BTB_SIZE];    // Slot 0 is the newest entry
bp_btb_pkg::btb_update_t ref_upd;               // Write request waiting for the next edge
bp_arch_pkg::addr_t      ref_fetch_pc;

// First slot holding pc, -1 on a miss
function automatic int find_slot(input bp_arch_pkg::addr_t pc);
    int hit;
    hit = -1;
    for (int i = 0; i < BTB_SIZE; i++) begin
        if (hit < 0 && ref_tbl[i].pc == pc) begin
            hit = i;
        end
    end
    return hit;
endfunction

function automatic void expected_chain(input bp_arch_pkg::addr_t start,
                                       output bp_arch_pkg::addr_t [BP_DEPTH-1:0] npc,
                                       output logic [BP_DEPTH-1:0] exec);
    int hit;
    npc[0]  = start;
    exec[0] = 1'b0;
    for (int d = 1; d < BP_DEPTH; d++) begin
        hit     = find_slot(npc[d-1]);
        npc[d]  = (hit < 0) ? npc[d-1] + bp_arch_pkg::INSTR_STEP : ref_tbl[hit].npc;
        exec[d] = (hit >= 0) && ref_tbl[hit].exec;
    end
endfunction

// One rising edge, all three stages from their old state
task automatic advance_model();
    bp_arch_pkg::addr_t [BP_DEPTH-1:0] npc;
    logic [BP_DEPTH-1:0]               exec;
    int                                hit;
    expected_chain(ref_fetch_pc, npc, exec);
    if (i_redirect) begin
        ref_fetch_pc = i_redirect_pc;
    end else if (i_fetch_en) begin
        ref_fetch_pc = npc[1];
    end
    hit = find_slot(ref_upd.pc);
    if (i_flush) begin
        for (int i = 0; i < BTB_SIZE; i++) begin
            ref_tbl[i].pc   = bp_arch_pkg::EMPTY_TAG;
            ref_tbl[i].exec = 1'b0;
        end
    end else if (ref_upd.we && !(hit >= 0 && ref_tbl[hit].exec && !ref_upd.exec)) begin
        for (int i = BTB_SIZE - 1; i > 0; i--) begin
            if (hit < 0 || i <= hit) begin
                ref_tbl[i] = ref_tbl[i-1];      // A miss pushes the last slot out
            end
        end
        ref_tbl[0] = '{pc: ref_upd.pc, npc: ref_upd.npc, exec: ref_upd.exec};
    end
    ref_upd.we   = i_ex_valid ||
                   (i_dec_valid && i_dec_npc != i_dec_pc + bp_arch_pkg::INSTR_STEP);
    ref_upd.exec = i_ex_valid;
    ref_upd.pc   = i_ex_valid ? i_ex_pc : i_dec_pc;
    ref_upd.npc  = i_ex_valid ? i_ex_npc : i_dec_npc;
endtask

`endif

/* verif/bp_tb.sv */
/*
  Testbench for bp_top with default parameters (8 entries, chain depth 4).
  The reference model steps on each rising edge and is compared on each falling edge.
*/

module bp_tb;

    localparam int BTB_SIZE = 8;
    localparam int BP_DEPTH = 4;

    logic i_clk, i_nrst, i_flush, i_ex_valid, i_dec_valid, i_fetch_en, i_redirect;
    bp_arch_pkg::addr_t i_ex_pc, i_ex_npc, i_dec_pc, i_dec_npc, i_redirect_pc, o_fetch_pc;
    bp_arch_pkg::addr_t [BP_DEPTH-1:0] o_pred_npc;
    bp_arch_pkg::addr_t [BP_DEPTH-1:0] exp_npc;
    logic [BP_DEPTH-1:0] o_pred_exec;
    logic [BP_DEPTH-1:0] exp_exec;
    logic [31:0] r;
    integer seed;
    int errors, checks, tests, mark;

    bp_top DUT (.*);

    `include "bp_tb_ref.svh"

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        if (!i_nrst) begin
            for (int i = 0; i < BTB_SIZE; i++) begin
                ref_tbl[i] = '{pc: bp_arch_pkg::EMPTY_TAG, npc: '0, exec: 1'b0};
            end
            ref_upd      = '0;
            ref_fetch_pc = bp_arch_pkg::RESET_PC;
        end else begin
            advance_model();
        end
    end

    always @(negedge i_clk) begin
        if (i_nrst) begin
            expected_chain(ref_fetch_pc, exp_npc, exp_exec);
            check("fetch pc", o_fetch_pc, ref_fetch_pc);
            for (int d = 0; d < BP_DEPTH; d++) begin
                check("chain npc", o_pred_npc[d], exp_npc[d]);
            end
            check("chain exec", 64'(o_pred_exec), 64'(exp_exec));
        end
    end

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic step();
        @(posedge i_clk);
        #2;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - mark);
        mark = errors;
    endtask

    task automatic send_report(input logic ex_v, input bp_arch_pkg::addr_t ex_pc,
                               input bp_arch_pkg::addr_t ex_npc, input logic dec_v,
                               input bp_arch_pkg::addr_t dec_pc,
                               input bp_arch_pkg::addr_t dec_npc);
        i_ex_valid  = ex_v;
        i_ex_pc     = ex_pc;
        i_ex_npc    = ex_npc;
        i_dec_valid = dec_v;
        i_dec_pc    = dec_pc;
        i_dec_npc   = dec_npc;
        step();
        i_ex_valid  = 1'b0;
        i_dec_valid = 1'b0;
    endtask

    task automatic redirect(input bp_arch_pkg::addr_t pc);
        i_redirect    = 1'b1;
        i_redirect_pc = pc;
        step();
        i_redirect = 1'b0;
    endtask

    task automatic flush_table();
        i_flush = 1'b1;
        step();
        i_flush = 1'b0;
    endtask

    // Fetch from pc and look at the first predicted step
    task automatic check_hit(input bp_arch_pkg::addr_t pc, input bp_arch_pkg::addr_t npc,
                             input logic exec);
        redirect(pc);
        check("predicted target", o_pred_npc[1], npc);
        check("predicted exec", 64'(o_pred_exec[1]), 64'(exec));
    endtask

    task automatic wait_fetch(input bp_arch_pkg::addr_t target, input int limit);
        int n;
        n = 0;
        while (o_fetch_pc != target && n < limit) begin
            step();
            n++;
        end
        if (o_fetch_pc != target) begin
            errors++;
            $display("timeout: fetch address did not reach %h in %0d cycles", target, limit);
        end
    endtask

    // Aligned address in a 512-byte window so that random reports hit
    function automatic bp_arch_pkg::addr_t rand_addr();
        logic [31:0] v;
        v = $random(seed);
        return 64'h8000 + {55'd0, v[8:2], 2'b00};
    endfunction

    initial begin
        seed   = 32'h0e8e_17d1;
        errors = 0;
        checks = 0;
        tests  = 0;
        mark   = 0;
        i_nrst = 1'b0;
        i_flush = 1'b0;
        i_fetch_en = 1'b0;
        i_redirect = 1'b0;
        i_redirect_pc = '0;
        send_report(0, '0, '0, 0, '0, '0);
        repeat (3) @(posedge i_clk);
        #2;
        i_nrst = 1'b1;

        check("reset fetch pc", o_fetch_pc, bp_arch_pkg::RESET_PC);
        for (int d = 0; d < BP_DEPTH; d++) begin
            check("reset chain", o_pred_npc[d], bp_arch_pkg::RESET_PC + 64'(4 * d));
        end
        check("reset exec", 64'(o_pred_exec), 64'd0);
        end_test("reset state");

        redirect(64'h100);
        send_report(1, 64'h100, 64'h200, 0, '0, '0);
        check("chain before write", o_pred_npc[1], 64'h104);
        step();
        check("chain after write", o_pred_npc[1], 64'h200);
        check("exec after write", 64'(o_pred_exec[1]), 64'd1);
        send_report(1, 64'h200, 64'h300, 0, '0, '0);
        send_report(1, 64'h300, 64'h400, 0, '0, '0);
        step();
        check("linked chain", o_pred_npc[3], 64'h400);
        check("linked exec", 64'(o_pred_exec), 64'b1110);
        end_test("executed reports");

        flush_table();
        for (int k = 0; k < 9; k++) begin
            send_report(1, 64'h2000 + 64'(k * 16), 64'h3000 + 64'(k * 16), 0, '0, '0);
        end
        check_hit(64'h2000, 64'h2004, 0);
        check_hit(64'h2010, 64'h3010, 1);
        send_report(1, 64'h2040, 64'h3040, 0, '0, '0);
        check_hit(64'h2010, 64'h3010, 1);       // Move from the middle keeps the tail
        send_report(1, 64'h2090, 64'h3090, 0, '0, '0);
        check_hit(64'h2010, 64'h2014, 0);       // Oldest after the move
        check_hit(64'h2040, 64'h3040, 1);
        check_hit(64'h2020, 64'h3020, 1);
        end_test("eviction and MRU move");

        send_report(0, '0, '0, 1, 64'h5000, 64'h5300);
        send_report(0, '0, '0, 1, 64'h5000, 64'h5004);  // Fall-through target is filtered
        check_hit(64'h5000, 64'h5300, 0);
        send_report(1, 64'h5100, 64'h5200, 1, 64'h5180, 64'h5300);
        check_hit(64'h5180, 64'h5184, 0);
        check_hit(64'h5100, 64'h5200, 1);
        send_report(0, '0, '0, 1, 64'h5100, 64'h5400);
        check_hit(64'h5100, 64'h5200, 1);
        send_report(0, '0, '0, 1, 64'h5500, 64'h5600);
        check_hit(64'h5500, 64'h5600, 0);
        end_test("pre-decoded reports");

        redirect(64'h5100);
        flush_table();
        check("chain after flush", o_pred_npc[1], 64'h5104);
        send_report(1, 64'h6000, 64'h6100, 0, '0, '0);
        flush_table();                          // Same edge as the pending write
        check_hit(64'h6000, 64'h6004, 0);
        end_test("flush");

        send_report(1, 64'h7000, 64'h7100, 0, '0, '0);
        send_report(1, 64'h7100, 64'h7200, 0, '0, '0);
        i_fetch_en = 1'b1;
        redirect(64'h7000);
        wait_fetch(64'h7200, 8);
        i_fetch_en = 1'b0;
        step();
        step();
        check("held fetch pc", o_fetch_pc, 64'h7200);
        for (int n = 0; n < 300; n++) begin
            r = $random(seed);
            i_ex_valid    = r[0] & r[1];
            i_dec_valid   = r[2];
            i_ex_pc       = rand_addr();
            i_ex_npc      = rand_addr();
            i_dec_pc      = rand_addr();
            i_dec_npc     = r[3] ? i_dec_pc + bp_arch_pkg::INSTR_STEP : rand_addr();
            i_fetch_en    = r[4] | r[5];
            i_redirect    = (r[8:6] == 3'd0);
            i_redirect_pc = rand_addr();
            i_flush       = (r[15:10] == 6'd0);
            step();
        end
        send_report(0, '0, '0, 0, '0, '0);
        i_redirect = 1'b0;
        i_flush    = 1'b0;
        step();
        end_test("fetch sequencing and random mix");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bp.f */
+incdir+verif
source/bp_arch_pkg.sv
source/bp_btb_pkg.sv
source/bp_update_arb.sv
source/bp_btb.sv
source/bp_fetch_seq.sv
source/bp_top.sv
verif/bp_tb.sv

/* run_verilator.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module bp_tb -f bp.f -o bp_sim \
    && ./obj_dir/bp_sim | tee /dev/stderr | grep -q "^RESULT: PASS$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
